// File: flist.f
+incdir+logic
logic/exerciser_pkg.sv
logic/fifo_lane.sv
logic/burst_writer.sv
logic/drain_checker.sv
logic/status_reporter.sv
logic/fifo_exerciser.sv
dv/clock_gen.sv
dv/tb_fifo_exerciser.sv

// File: Makefile
# Verilator build and run for the FIFO exerciser testbench
VERILATOR ?= verilator
TOP       ?= tb_fifo_exerciser
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# exit status comes from the search for the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_fifo_exerciser.sv
// ##########################################################################
// Directed tests for the FIFO exerciser. Inputs change 2 ns after the
// rising edge and outputs are sampled on the falling edge. The UART
// decoder assumes EX_BAUD_DIV is even and at least 4.
// ##########################################################################
`timescale 1ns/1ps
`include "exerciser_settings.svh"

module tb_fifo_exerciser;

	import exerciser_pkg::*;

	localparam int CLEAN_CYCLES   = 200 * `EX_PACE;
	localparam int HOLD_CYCLES    = 4 * `EX_LANES * `EX_DEPTH;
	localparam int RESUME_LIMIT   = 4 * `EX_PACE;
	localparam int OVERRUN_LIMIT  = 4 * `EX_LANES * `EX_DEPTH + 64;
	localparam int FRAME_LIMIT    = 14 * `EX_BAUD_DIV;
	localparam int TEST_CYCLES    = 16 + 2 * CLEAN_CYCLES + HOLD_CYCLES + 2 * RESUME_LIMIT
	                                + OVERRUN_LIMIT + FRAME_LIMIT;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4 + 100;

	// werror alone, and the ascii digit that goes with it
	localparam logic [2:0] OVERRUN_CODE = 3'b010;
	localparam logic [7:0] OVERRUN_CHAR = 8'h32;

	logic        clk;
	logic        fifo_reset;
	logic        reset_request;
	write_mode_t mode;
	logic        drain_hold;
	logic        serial;
	logic [2:0]  error_code;
	logic [15:0] words_checked;
	int          value_errors;
	int          other_errors;
	int          cycle_count;

	clock_gen clkgen0 (
		.reset_request (reset_request),
		.clk           (clk),
		.fifo_reset    (fifo_reset)
	);

	fifo_exerciser dut0 (
		.clk           (clk),
		.fifo_reset    (fifo_reset),
		.mode          (mode),
		.drain_hold    (drain_hold),
		.serial        (serial),
		.error_code    (error_code),
		.words_checked (words_checked)
	);

	task automatic report_mismatch(input string test, input int expected, input int actual);
		value_errors++;
		$display("[FAIL] %s: expected %0d, actual %0d", test, expected, actual);
	endtask

	task automatic set_inputs(input write_mode_t new_mode, input logic hold);
		@(posedge clk);
		#2;
		mode       = new_mode;
		drain_hold = hold;
	endtask

	// waits for the start bit, then samples each bit near its middle
	task automatic decode_uart_char(output logic [7:0] ch, output logic ok);
		int waited;
		waited = 0;
		ch     = '0;
		ok     = 1'b0;
		while (serial !== 1'b0 && waited < 4 * `EX_BAUD_DIV) begin
			@(negedge clk);
			waited++;
		end
		if (serial === 1'b0) begin
			repeat (`EX_BAUD_DIV / 2) @(negedge clk);
			ok = (serial === 1'b0);
			for (int i = 0; i < 8; i++) begin
				repeat (`EX_BAUD_DIV) @(negedge clk);
				ch[i] = serial;
			end
			repeat (`EX_BAUD_DIV) @(negedge clk);
			ok = ok && (serial === 1'b1);
		end
	endtask

	task automatic check_reset_state();
		wait (fifo_reset === 1'b0);
		@(negedge clk);
		if (serial !== 1'b1) begin
			report_mismatch("reset serial", 1, int'(serial));
		end
		if (error_code !== 3'd0) begin
			report_mismatch("reset error_code", 0, int'(error_code));
		end
		if (words_checked !== 16'd0) begin
			report_mismatch("reset words_checked", 0, int'(words_checked));
		end
	endtask

	task automatic clean_credit_run(input string test);
		logic [15:0] last_count;
		logic        serial_fell;
		logic        went_back;
		logic        code_seen;
		serial_fell = 1'b0;
		went_back   = 1'b0;
		code_seen   = 1'b0;
		set_inputs(MODE_CREDIT, 1'b0);
		@(negedge clk);
		last_count = words_checked;
		repeat (CLEAN_CYCLES) begin
			@(negedge clk);
			if (serial !== 1'b1 && !serial_fell) begin
				serial_fell = 1'b1;
				report_mismatch({test, " serial"}, 1, int'(serial));
			end
			if (error_code !== 3'd0 && !code_seen) begin
				code_seen = 1'b1;
				report_mismatch({test, " error_code"}, 0, int'(error_code));
			end
			if (words_checked < last_count && !went_back) begin
				went_back = 1'b1;
				report_mismatch({test, " words_checked backwards"}, int'(last_count),
				                int'(words_checked));
			end
			last_count = words_checked;
		end
		// about one pop per pace period
		if (words_checked < 16'd150) begin
			report_mismatch({test, " words_checked minimum"}, 150, int'(words_checked));
		end
	endtask

	task automatic back_pressure_test();
		logic [15:0] held_count;
		int          waited;
		set_inputs(MODE_CREDIT, 1'b1);
		@(negedge clk);
		held_count = words_checked;
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			if (words_checked !== held_count) begin
				report_mismatch("back-pressure hold", int'(held_count), int'(words_checked));
				held_count = words_checked;
			end
		end
		// error_code is sticky, so one look covers the whole stall
		if (error_code !== 3'd0) begin
			report_mismatch("back-pressure error_code", 0, int'(error_code));
		end
		set_inputs(MODE_CREDIT, 1'b0);
		waited = 0;
		while (words_checked === held_count && waited < RESUME_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (words_checked === held_count) begin
			other_errors++;
			$display("ERROR: back-pressure: no word checked within %0d cycles of release",
			         RESUME_LIMIT);
		end
	endtask

	task automatic overrun_detection();
		logic [7:0]  ch;
		logic        ok;
		logic [15:0] frozen_count;
		int          waited;
		set_inputs(MODE_FLOOD, 1'b1);
		waited = 0;
		@(negedge clk);
		while (error_code === 3'd0 && waited < OVERRUN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (error_code !== OVERRUN_CODE) begin
			report_mismatch("overrun error_code", int'(OVERRUN_CODE), int'(error_code));
		end
		decode_uart_char(ch, ok);
		if (!ok) begin
			other_errors++;
			$display("ERROR: overrun: no complete UART frame after the error was latched");
		end else if (ch !== OVERRUN_CHAR) begin
			report_mismatch("overrun uart char", int'(OVERRUN_CHAR), int'(ch));
		end
		// lanes hold data, only halt keeps the checker from popping
		set_inputs(MODE_FLOOD, 1'b0);
		@(negedge clk);
		frozen_count = words_checked;
		repeat (RESUME_LIMIT) begin
			@(negedge clk);
			if (words_checked !== frozen_count) begin
				report_mismatch("overrun halted words_checked", int'(frozen_count),
				                int'(words_checked));
				frozen_count = words_checked;
			end
		end
	endtask

	task automatic recover_after_reset();
		@(posedge clk);
		#2;
		reset_request = 1'b1;
		mode          = MODE_CREDIT;
		drain_hold    = 1'b0;
		@(posedge clk);
		#2;
		reset_request = 1'b0;
		@(negedge clk);
		if (error_code !== 3'd0) begin
			report_mismatch("recovery error_code", 0, int'(error_code));
		end
		if (words_checked !== 16'd0) begin
			report_mismatch("recovery words_checked", 0, int'(words_checked));
		end
		clean_credit_run("recovery clean run");
	endtask

	task automatic finish_run();
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			other_errors++;
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			finish_run();
		end
	end

	initial begin
		value_errors  = 0;
		other_errors  = 0;
		cycle_count   = 0;
		reset_request = 1'b0;
		mode          = MODE_CREDIT;
		drain_hold    = 1'b0;
		check_reset_state();
		clean_credit_run("clean credit run");
		back_pressure_test();
		overrun_detection();
		recover_after_reset();
		finish_run();
	end

endmodule

// File: dv/clock_gen.sv
// ##########################################################################
// Testbench clock with a 20 ns period. fifo_reset is high for the first
// 8 rising edges and again whenever reset_request is high.
// ##########################################################################
`timescale 1ns/1ps

module clock_gen (
	input  logic reset_request,
	output logic clk,
	output logic fifo_reset
);

	logic power_on_reset;

	initial begin
		clk            = 1'b0;
		power_on_reset = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		power_on_reset = 1'b0;
	end

	always #10 clk = ~clk;

	assign fifo_reset = power_on_reset || reset_request;

endmodule

// File: logic/fifo_exerciser.sv
// ##########################################################################
// FIFO exerciser top: burst writer, EX_LANES FIFO lanes, drain checker
// and status reporter. serial idles high and carries one error character.
// ##########################################################################
`timescale 1ns/1ps
`include "exerciser_settings.svh"

module fifo_exerciser (
	input  logic                       clk,
	input  logic                       fifo_reset,
	input  exerciser_pkg::write_mode_t mode,
	input  logic                       drain_hold,
	output logic                       serial,
	output logic [2:0]                 error_code,
	output logic [15:0]                words_checked
);

	logic [`EX_LANES-1:0]           lane_write;
	logic [`EX_WIDTH-1:0]           write_data;
	logic [`EX_LANES-1:0]           lane_read;
	logic [`EX_LANES-1:0]           data_available;
	logic [`EX_LANES*`EX_WIDTH-1:0] read_data;
	logic [`EX_LANES-1:0]           lane_werror;
	logic [`EX_LANES-1:0]           lane_rerror;
	logic                           mismatch;
	logic                           halt;

	burst_writer writer0 (
		.clk        (clk),
		.fifo_reset (fifo_reset),
		.mode       (mode),
		.halt       (halt),
		.lane_read  (lane_read),
		.lane_write (lane_write),
		.write_data (write_data)
	);

	// write data is shared, lane_write selects the lane
	for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
		fifo_lane lane (
			.clk            (clk),
			.fifo_reset     (fifo_reset),
			.write_strobe   (lane_write[i]),
			.write_data     (write_data),
			.read_strobe    (lane_read[i]),
			.read_data      (read_data[i*`EX_WIDTH +: `EX_WIDTH]),
			.data_available (data_available[i]),
			.werror         (lane_werror[i]),
			.rerror         (lane_rerror[i])
		);
	end

	drain_checker checker0 (
		.clk            (clk),
		.fifo_reset     (fifo_reset),
		.halt           (halt),
		.drain_hold     (drain_hold),
		.data_available (data_available),
		.read_data      (read_data),
		.lane_read      (lane_read),
		.mismatch       (mismatch),
		.words_checked  (words_checked)
	);

	status_reporter reporter0 (
		.clk         (clk),
		.fifo_reset  (fifo_reset),
		.lane_werror (lane_werror),
		.lane_rerror (lane_rerror),
		.mismatch    (mismatch),
		.halt        (halt),
		.error_code  (error_code),
		.serial      (serial)
	);

endmodule

// File: logic/status_reporter.sv
// ##########################################################################
// Latches the first error, halts traffic and sends one 8N1 character
// ('0' plus the error bits) at EX_BAUD_DIV clocks per bit. The start bit
// leaves two cycles after the error pulse. Stays halted until fifo_reset.
// ##########################################################################
`timescale 1ns/1ps
`include "exerciser_settings.svh"

module status_reporter (
	input  logic                 clk,
	input  logic                 fifo_reset,
	input  logic [`EX_LANES-1:0] lane_werror,
	input  logic [`EX_LANES-1:0] lane_rerror,
	input  logic                 mismatch,
	output logic                 halt,
	output logic [2:0]           error_code,
	output logic                 serial
);

	import exerciser_pkg::*;

	localparam int BW = $clog2(`EX_BAUD_DIV);

	rep_state_t    state;
	logic [2:0]    err_now;
	logic [7:0]    tx_char;
	logic [9:0]    tx_shift;
	logic [BW-1:0] baud_cnt;
	logic [3:0]    bit_cnt;
	logic          bit_end;

	// lanes are or-ed together, only the error kind matters
	always_comb begin
		err_now             = '0;
		err_now[ERR_RERROR] = |lane_rerror;
		err_now[ERR_WERROR] = |lane_werror;
		err_now[ERR_DERROR] = mismatch;
	end

	assign tx_char = ERR_CHAR_BASE + {5'b0, err_now};
	assign bit_end = (baud_cnt == BW'(`EX_BAUD_DIV - 1));

	always_ff @(posedge clk) begin
		if (fifo_reset) begin
			state      <= REP_RUN;
			halt       <= 1'b0;
			error_code <= '0;
			serial     <= 1'b1;
			baud_cnt   <= '0;
			bit_cnt    <= '0;
		end else begin
			case (state)
				REP_RUN: begin
					serial <= 1'b1;
					if (err_now != '0) begin
						error_code <= err_now;
						halt       <= 1'b1;
						// stop, data lsb first, start
						tx_shift   <= {1'b1, tx_char, 1'b0};
						baud_cnt   <= '0;
						bit_cnt    <= '0;
						state      <= REP_SEND;
					end
				end

				REP_SEND: begin
					serial <= tx_shift[0];
					if (bit_end) begin
						baud_cnt <= '0;
						tx_shift <= {1'b1, tx_shift[9:1]};
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd9) begin
							state <= REP_HALT;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end

				REP_HALT: begin
					// line idles high, traffic frozen
					serial <= 1'b1;
				end

				default: begin
					state <= REP_HALT;
				end
			endcase
		end
	end

endmodule

// File: logic/drain_checker.sv
// ##########################################################################
// Slow round-robin drain, one pop per EX_PACE cycles at most. Each popped
// byte is compared with that lane's expected counter; a mismatch pulses
// one cycle after the pop. drain_hold and halt both stop popping.
// ##########################################################################
`timescale 1ns/1ps
`include "exerciser_settings.svh"

module drain_checker (
	input  logic                           clk,
	input  logic                           fifo_reset,
	input  logic                           halt,
	input  logic                           drain_hold,
	input  logic [`EX_LANES-1:0]           data_available,
	input  logic [`EX_LANES*`EX_WIDTH-1:0] read_data,
	output logic [`EX_LANES-1:0]           lane_read,
	output logic                           mismatch,
	output logic [15:0]                    words_checked
);

	localparam int LW  = (`EX_LANES > 1) ? $clog2(`EX_LANES) : 1;
	localparam int PCW = $clog2(`EX_PACE);

	logic [PCW-1:0]       pace_cnt;
	logic                 pace_tick;
	logic [LW-1:0]        rr_ptr;
	logic                 found;
	logic [LW-1:0]        sel;
	logic                 pop_en;
	logic [`EX_WIDTH-1:0] head;
	logic [`EX_WIDTH-1:0] expected [`EX_LANES];

	assign pace_tick = (pace_cnt == PCW'(`EX_PACE - 1));

	// next lane with data, starting after the last one popped
	always_comb begin
		int idx;
		found = 1'b0;
		sel   = rr_ptr;
		for (int k = 0; k < `EX_LANES; k++) begin
			idx = int'(rr_ptr) + 1 + k;
			if (idx >= `EX_LANES) begin
				idx = idx - `EX_LANES;
			end
			if (!found && data_available[idx]) begin
				found = 1'b1;
				sel   = LW'(idx);
			end
		end
	end

	assign pop_en = pace_tick && !halt && !drain_hold && found;
	assign head   = read_data[sel * `EX_WIDTH +: `EX_WIDTH];

	// pop is combinational so the head is compared on the same edge
	always_comb begin
		lane_read = '0;
		if (pop_en) begin
			lane_read[sel] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_reset) begin
			pace_cnt      <= '0;
			rr_ptr        <= '0;
			mismatch      <= 1'b0;
			words_checked <= '0;
			for (int i = 0; i < `EX_LANES; i++) begin
				expected[i] <= '0;
			end
		end else begin
			if (pace_tick) begin
				pace_cnt <= '0;
			end else begin
				pace_cnt <= pace_cnt + 1'b1;
			end

			mismatch <= 1'b0;
			if (pop_en) begin
				rr_ptr        <= sel;
				mismatch      <= (head != expected[sel]);
				expected[sel] <= expected[sel] + 1'b1;
				words_checked <= words_checked + 1'b1;
			end
		end
	end

endmodule

// File: logic/burst_writer.sv
// ##########################################################################
// Round-robin pattern writer, one write per cycle at most. Each pop seen on
// lane_read returns one credit. In flood mode credits are still counted
// but do not gate writes, so lanes can be overrun on purpose.
// ##########################################################################
`timescale 1ns/1ps
`include "exerciser_settings.svh"

module burst_writer (
	input  logic                      clk,
	input  logic                      fifo_reset,
	input  exerciser_pkg::write_mode_t mode,
	input  logic                      halt,
	input  logic [`EX_LANES-1:0]      lane_read,
	output logic [`EX_LANES-1:0]      lane_write,
	output logic [`EX_WIDTH-1:0]      write_data
);

	import exerciser_pkg::*;

	localparam int LW  = (`EX_LANES > 1) ? $clog2(`EX_LANES) : 1;
	localparam int CRW = $clog2(`EX_DEPTH) + 2;

	logic [CRW-1:0]       credit  [`EX_LANES];
	logic [`EX_WIDTH-1:0] pattern [`EX_LANES];
	logic [LW-1:0]        rr_ptr;
	logic [`EX_LANES-1:0] eligible;
	logic                 found;
	logic [LW-1:0]        sel;

	always_comb begin
		for (int i = 0; i < `EX_LANES; i++) begin
			eligible[i] = !halt && (mode == MODE_FLOOD || credit[i] != '0);
		end
	end

	// next eligible lane after the last one written
	always_comb begin
		int idx;
		found = 1'b0;
		sel   = rr_ptr;
		for (int k = 0; k < `EX_LANES; k++) begin
			idx = int'(rr_ptr) + 1 + k;
			if (idx >= `EX_LANES) begin
				idx = idx - `EX_LANES;
			end
			if (!found && eligible[idx]) begin
				found = 1'b1;
				sel   = LW'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_reset) begin
			lane_write <= '0;
			rr_ptr     <= '0;
			for (int i = 0; i < `EX_LANES; i++) begin
				credit[i]  <= CRW'(`EX_DEPTH);
				pattern[i] <= '0;
			end
		end else begin
			lane_write <= '0;
			if (found) begin
				lane_write[sel] <= 1'b1;
				rr_ptr          <= sel;
				write_data      <= pattern[sel];
				pattern[sel]    <= pattern[sel] + 1'b1;
			end

			// take on write, give back on pop; saturate at zero in flood mode
			for (int i = 0; i < `EX_LANES; i++) begin
				case ({found && (sel == LW'(i)), lane_read[i]})
					2'b10: begin
						if (credit[i] != '0) begin
							credit[i] <= credit[i] - 1'b1;
						end
					end
					2'b01:   credit[i] <= credit[i] + 1'b1;
					default: credit[i] <= credit[i];
				endcase
			end
		end
	end

endmodule

// File: logic/fifo_lane.sv
// ##########################################################################
// First-word-fall-through FIFO lane, EX_DEPTH entries of EX_WIDTH bits.
// A write when full or a read when empty is dropped and flagged with a
// one-cycle error pulse on the following cycle.
// ##########################################################################
`timescale 1ns/1ps
`include "exerciser_settings.svh"

module fifo_lane (
	input  logic                 clk,
	input  logic                 fifo_reset,
	input  logic                 write_strobe,
	input  logic [`EX_WIDTH-1:0] write_data,
	input  logic                 read_strobe,
	output logic [`EX_WIDTH-1:0] read_data,
	output logic                 data_available,
	output logic                 werror,
	output logic                 rerror
);

	localparam int PW = $clog2(`EX_DEPTH);

	logic [`EX_WIDTH-1:0] mem [`EX_DEPTH];
	logic [PW-1:0]        wr_ptr;
	logic [PW-1:0]        rd_ptr;
	logic [PW:0]          fill_count;
	logic                 full;
	logic                 empty;
	logic                 do_write;
	logic                 do_read;

	assign full  = (fill_count == (PW+1)'(`EX_DEPTH));
	assign empty = (fill_count == '0);

	// illegal accesses never touch the storage
	assign do_write = write_strobe && !full;
	assign do_read  = read_strobe && !empty;

	// head word always on the output
	assign read_data      = mem[rd_ptr];
	assign data_available = !empty;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= write_data;
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_count <= '0;
			werror     <= 1'b0;
			rerror     <= 1'b0;
		end else begin
			werror <= write_strobe && full;
			rerror <= read_strobe && empty;

			// pointers wrap on their own, depth is a power of two
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({do_write, do_read})
				2'b10:   fill_count <= fill_count + 1'b1;
				2'b01:   fill_count <= fill_count - 1'b1;
				default: fill_count <= fill_count;
			endcase
		end
	end

endmodule

// File: logic/exerciser_pkg.sv
// ##########################################################################
// Shared types for the FIFO exerciser. The error code is three bits wide
// and the UART character is ERR_CHAR_BASE plus that code.
// ##########################################################################
package exerciser_pkg;

	// writer flow control
	typedef enum logic {
		MODE_CREDIT = 1'b0,
		MODE_FLOOD  = 1'b1
	} write_mode_t;

	// status reporter FSM
	typedef enum logic [1:0] {
		REP_RUN  = 2'd0,
		REP_SEND = 2'd1,
		REP_HALT = 2'd2
	} rep_state_t;

	// bit positions in the error code
	localparam int ERR_RERROR = 0;
	localparam int ERR_WERROR = 1;
	localparam int ERR_DERROR = 2;

	// ascii '0'
	localparam logic [7:0] ERR_CHAR_BASE = 8'h30;

endpackage

// File: logic/exerciser_settings.svh
// ##########################################################################
// Build-time settings for the FIFO exerciser. EX_DEPTH must be a power of
// two and at least 2; EX_PACE and EX_BAUD_DIV must be at least 2.
// EX_DEPTH also sets the starting credit count of every lane.
// ##########################################################################
`ifndef EXERCISER_SETTINGS_SVH
`define EXERCISER_SETTINGS_SVH

// number of fifo lanes under test
`define EX_LANES 4

// entries per lane, also initial credits
`define EX_DEPTH 8

// data width of each lane
`define EX_WIDTH 8

// cycles between drain attempts
`define EX_PACE 16

// clock cycles per uart bit
`define EX_BAUD_DIV 8

`endif
